/* fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// instruction RAM word index width, 128 words
`define IMEM_ADDR_W 7

// program counter value after reset
`define RESET_PC 32'h0000_0000

// syscall entry point
`define EXC_VECTOR 32'h0000_0040

`endif

/* fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [`IMEM_ADDR_W-1:0] imem_addr_t;

    // redirect source select for the fetch target mux
    typedef logic [1:0] pc_sel_t;

    localparam pc_sel_t PC_SEL_REL = 2'b00;
    localparam pc_sel_t PC_SEL_REG = 2'b01;
    localparam pc_sel_t PC_SEL_IDX = 2'b10;
    localparam pc_sel_t PC_SEL_EXC = 2'b11;

    // decode side to fetch, every candidate target travels along
    typedef struct packed {
        logic    valid;
        pc_sel_t sel;
        word_t   rega;
        pc_t     imm_target;
        pc_t     index_target;
    } redirect_t;

    typedef struct packed {
        pc_t   nextpc;
        word_t instruc;
    } if_id_t;

    // write port of the instruction RAM, used before the program runs
    typedef struct packed {
        logic       load;
        imem_addr_t addr;
        word_t      data;
    } ram_load_t;

endpackage

/* instr_ram.sv */
`timescale 1ns/1ps

`include "fetch_config.svh"

module instr_ram (
    input  logic                  clock,
    input  logic                  reset,
    input  fetch_pkg::imem_addr_t addr,
    input  fetch_pkg::ram_load_t  ram_load,
    output fetch_pkg::word_t      data
);

    localparam int DEPTH = 1 << `IMEM_ADDR_W;

    fetch_pkg::word_t mem [0:DEPTH-1];

    logic write_en;

    // a load strobe seen while reset is still held is dropped
    assign write_en = reset && ram_load.load;

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[ram_load.addr] <= ram_load.data;
        end
    end

    // asynchronous read so the fetched word is ready in the same cycle as the PC
    assign data = mem[addr];

endmodule

/* fetch.sv */
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  stall,
    input  fetch_pkg::word_t      instr,
    input  fetch_pkg::redirect_t  redirect,
    output fetch_pkg::imem_addr_t imem_addr,
    output fetch_pkg::if_id_t     if_id
);

    fetch_pkg::pc_t    pc;
    fetch_pkg::pc_t    pc_plus4;
    fetch_pkg::pc_t    target;
    fetch_pkg::pc_t    pc_next;
    fetch_pkg::if_id_t if_id_next;

    // word index into the instruction RAM, byte offset bits dropped
    assign imem_addr = pc[`IMEM_ADDR_W+1:2];

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (redirect.sel)
            fetch_pkg::PC_SEL_REL: begin
                target = redirect.imm_target;
            end
            fetch_pkg::PC_SEL_REG: begin
                target = redirect.rega;
            end
            fetch_pkg::PC_SEL_IDX: begin
                target = redirect.index_target;
            end
            default: begin
                target = `EXC_VECTOR;
            end
        endcase
    end

    // a stall holds the PC and sends a zero bubble with the held PC
    always_comb begin
        pc_next            = pc;
        if_id_next.nextpc  = pc;
        if_id_next.instruc = '0;
        if (!stall) begin
            // the word at the old PC still goes down, it is the delay slot on a redirect
            if_id_next.instruc = instr;
            if (redirect.valid) begin
                pc_next           = target;
                if_id_next.nextpc = target;
            end else begin
                pc_next           = pc_plus4;
                if_id_next.nextpc = pc_plus4;
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            if_id <= '0;
        end else begin
            if_id <= if_id_next;
        end
    end

endmodule

/* redirect_unit.sv */
`timescale 1ns/1ps

module redirect_unit (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 stall,
    input  fetch_pkg::if_id_t    if_id,
    input  fetch_pkg::word_t     rega_value,
    output fetch_pkg::redirect_t redirect
);

    localparam logic [5:0] OP_SPECIAL = 6'd0;
    localparam logic [5:0] OP_J       = 6'd2;
    localparam logic [5:0] OP_BEQ     = 6'd4;
    localparam logic [5:0] FN_JR      = 6'd8;
    localparam logic [5:0] FN_SYSCALL = 6'd12;

    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [5:0]  funct;
    logic [15:0] imm;
    logic [25:0] index;

    fetch_pkg::redirect_t decoded;
    fetch_pkg::redirect_t pend_info;
    logic                 pend_valid;

    assign opcode = if_id.instruc[31:26];
    assign rs     = if_id.instruc[25:21];
    assign rt     = if_id.instruc[20:16];
    assign funct  = if_id.instruc[5:0];
    assign imm    = if_id.instruc[15:0];
    assign index  = if_id.instruc[25:0];

    // nextpc in IF/ID is the delay slot address, targets are based on it as in MIPS
    always_comb begin
        decoded.valid        = 1'b0;
        decoded.sel          = fetch_pkg::PC_SEL_REL;
        decoded.rega         = rega_value;
        decoded.imm_target   = if_id.nextpc + {{14{imm[15]}}, imm, 2'b00};
        decoded.index_target = {if_id.nextpc[31:28], index, 2'b00};
        case (opcode)
            OP_J: begin
                decoded.valid = 1'b1;
                decoded.sel   = fetch_pkg::PC_SEL_IDX;
            end
            OP_BEQ: begin
                // only the always-taken form with both registers zero
                if (rs == 5'd0 && rt == 5'd0) begin
                    decoded.valid = 1'b1;
                    decoded.sel   = fetch_pkg::PC_SEL_REL;
                end
            end
            OP_SPECIAL: begin
                if (funct == FN_JR) begin
                    decoded.valid = 1'b1;
                    decoded.sel   = fetch_pkg::PC_SEL_REG;
                end else if (funct == FN_SYSCALL) begin
                    decoded.valid = 1'b1;
                    decoded.sel   = fetch_pkg::PC_SEL_EXC;
                end
            end
            default: begin
                decoded.valid = 1'b0;
            end
        endcase
    end

    // the stall edge replaces the IF/ID word with a bubble, so the redirect is kept here
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pend_valid <= 1'b0;
        end else if (pend_valid) begin
            if (!stall) begin
                pend_valid <= 1'b0;
            end
        end else if (stall && decoded.valid) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!pend_valid && stall && decoded.valid) begin
            pend_info <= decoded;
        end
    end

    // a pending redirect wins over whatever sits in IF/ID meanwhile
    assign redirect = pend_valid ? pend_info : decoded;

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 is_stall,
    input  logic                 ex_stall,
    input  fetch_pkg::word_t     rega_value,
    input  fetch_pkg::ram_load_t ram_load,
    output fetch_pkg::if_id_t    if_id
);

    fetch_pkg::imem_addr_t imem_addr;
    fetch_pkg::word_t      imem_data;
    fetch_pkg::redirect_t  redirect;
    logic                  stall;

    // issue and execute stalls act the same on fetch
    assign stall = is_stall | ex_stall;

    instr_ram u_instr_ram (
        .clock    (clock),
        .reset    (reset),
        .addr     (imem_addr),
        .ram_load (ram_load),
        .data     (imem_data)
    );

    fetch u_fetch (
        .clock     (clock),
        .reset     (reset),
        .stall     (stall),
        .instr     (imem_data),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .if_id     (if_id)
    );

    redirect_unit u_redirect_unit (
        .clock      (clock),
        .reset      (reset),
        .stall      (stall),
        .if_id      (if_id),
        .rega_value (rega_value),
        .redirect   (redirect)
    );

endmodule

/* fetch_chk.sv */
`timescale 1ns/1ps

module fetch_chk (
    input logic                 clock,
    input logic                 reset,
    input logic                 stall,
    input fetch_pkg::pc_t       pc,
    input fetch_pkg::redirect_t redirect,
    input fetch_pkg::if_id_t    if_id
);

    // number of assertion failures so far
    int fail_count = 0;

    pc_word_aligned: assert property (
        @(posedge clock) disable iff (!reset) pc[1:0] == 2'b00
    ) else begin
        $error("PC %h is not word aligned", pc);
        fail_count++;
    end

    // a stalled edge always sends a bubble down to decode
    bubble_after_stall: assert property (
        @(posedge clock) disable iff (!reset) stall |=> if_id.instruc == '0
    ) else begin
        $error("instruc %h is not a bubble after a stall", if_id.instruc);
        fail_count++;
    end

    pc_held_in_stall: assert property (
        @(posedge clock) disable iff (!reset) stall |=> $stable(pc)
    ) else begin
        $error("PC moved to %h during a stall", pc);
        fail_count++;
    end

    // a redirect seen at a stalled edge is still offered, unchanged, at the next edge
    redirect_kept_in_stall: assert property (
        @(posedge clock) disable iff (!reset)
            stall && redirect.valid |=> redirect.valid && $stable(redirect)
    ) else begin
        $error("redirect was dropped or changed during a stall");
        fail_count++;
    end

endmodule

bind fetch fetch_chk u_fetch_chk (
    .clock    (clock),
    .reset    (reset),
    .stall    (stall),
    .pc       (pc),
    .redirect (redirect),
    .if_id    (if_id)
);

/* fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

    localparam int RECORD_WORDS  = 6;
    localparam int MAX_RECORDS   = 64;
    localparam int RESET_CYCLES  = 16;
    localparam int RESET_TIMEOUT = 100;

    localparam fetch_pkg::word_t KIND_END   = 32'd0;
    localparam fetch_pkg::word_t KIND_LOAD  = 32'd1;
    localparam fetch_pkg::word_t KIND_CYCLE = 32'd2;

    logic                 clock;
    logic                 reset;
    logic                 is_stall;
    logic                 ex_stall;
    fetch_pkg::word_t     rega_value;
    fetch_pkg::ram_load_t ram_load;
    fetch_pkg::if_id_t    if_id;

    // one record is a kind word followed by five fields
    fetch_pkg::word_t cases [0:RECORD_WORDS*MAX_RECORDS-1];

    int load_count;
    int cycle_count;

    fetch_top UUT (
        .clock      (clock),
        .reset      (reset),
        .is_stall   (is_stall),
        .ex_stall   (ex_stall),
        .rega_value (rega_value),
        .ram_load   (ram_load),
        .if_id      (if_id)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b1;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_pc(input string name, input fetch_pkg::pc_t actual,
                            input fetch_pkg::pc_t expected);
        if (actual !== expected) begin
            stop_run($sformatf("[FAIL] t=%0t %s got %h expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_word(input string name, input fetch_pkg::word_t actual,
                              input fetch_pkg::word_t expected);
        if (actual !== expected) begin
            stop_run($sformatf("[FAIL] t=%0t %s got %h expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic wait_for_reset_release();
        int waited;
        waited = 0;
        while (reset !== 1'b1) begin
            @(posedge clock);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                stop_run("reset was not released within the timeout");
            end
        end
    endtask

    // the write happens on the rising edge between the two falling edges
    task automatic load_word(input fetch_pkg::word_t addr, input fetch_pkg::word_t data);
        ram_load.load = 1'b1;
        ram_load.addr = fetch_pkg::imem_addr_t'(addr);
        ram_load.data = data;
        @(negedge clock);
        load_count++;
    endtask

    task automatic run_cycle(input fetch_pkg::word_t is_level, input fetch_pkg::word_t ex_level,
                             input fetch_pkg::word_t rega, input fetch_pkg::pc_t exp_nextpc,
                             input fetch_pkg::word_t exp_instruc);
        ram_load   = '0;
        is_stall   = is_level[0];
        ex_stall   = ex_level[0];
        rega_value = rega;
        @(negedge clock);
        cycle_count++;
        check_pc("if_id.nextpc", if_id.nextpc, exp_nextpc);
        check_word("if_id.instruc", if_id.instruc, exp_instruc);
    endtask

    always @(UUT.u_fetch.u_fetch_chk.fail_count) begin
        if (UUT.u_fetch.u_fetch_chk.fail_count != 0) begin
            stop_run("an assertion in fetch_chk failed");
        end
    end

    initial begin
        fetch_pkg::word_t kind;
        int               rec;
        int               base;
        bit               done;
        // the issue stall keeps the PC at the reset value while the RAM is loaded
        is_stall    = 1'b1;
        ex_stall    = 1'b0;
        rega_value  = '0;
        ram_load    = '0;
        load_count  = 0;
        cycle_count = 0;
        rec         = 0;
        done        = 1'b0;
        $readmemh("fetch_cases.txt", cases);
        wait_for_reset_release();
        @(negedge clock);
        while (!done && rec < MAX_RECORDS) begin
            base = rec * RECORD_WORDS;
            kind = cases[base];
            case (kind)
                KIND_END: begin
                    done = 1'b1;
                end
                KIND_LOAD: begin
                    load_word(cases[base+1], cases[base+2]);
                end
                KIND_CYCLE: begin
                    run_cycle(cases[base+1], cases[base+2], cases[base+3],
                              cases[base+4], cases[base+5]);
                end
                default: begin
                    stop_run($sformatf("record %0d of the cases file has an unknown kind", rec));
                end
            endcase
            rec++;
        end
        // one more edge so the bound assertions see the last cycle
        @(negedge clock);
        if (!done || load_count == 0 || cycle_count == 0) begin
            stop_run("the cases file has no end record or holds no loads or cycles");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* project.f */
+incdir+.
fetch_pkg.sv
instr_ram.sv
fetch.sv
redirect_unit.sv
fetch_top.sv
fetch_chk.sv
fetch_tb.sv

/* fetch_cases.txt */
// load record:  1 ram_word_index instruction 0 0 0
// cycle record: 2 is_stall ex_stall rega_value expected_nextpc expected_instruc
// end record:   0 0 0 0 0 0
// program with J at 0x08, BEQ at 0x24, JR at 0x38, SYSCALL at 0x64, J at 0x48
1 00 24010001 0 0 0
1 01 24010002 0 0 0
1 02 08000008 0 0 0
1 03 24010003 0 0 0
1 08 24010008 0 0 0
1 09 10000003 0 0 0
1 0a 2401000a 0 0 0
1 0d 2401000d 0 0 0
1 0e 03e00008 0 0 0
1 0f 2401000f 0 0 0
1 10 24010010 0 0 0
1 11 24010011 0 0 0
1 12 08000014 0 0 0
1 13 24010013 0 0 0
1 14 24010014 0 0 0
1 15 24010015 0 0 0
1 16 24010016 0 0 0
1 17 24010017 0 0 0
1 18 24010018 0 0 0
1 19 0000000c 0 0 0
1 1a 2401001a 0 0 0
// sequential fetch then J to 0x20 after its delay slot
2 0 0 00000000 00000004 24010001
2 0 0 00000000 00000008 24010002
2 0 0 00000000 0000000c 08000008
2 0 0 00000000 00000020 24010003
// BEQ to 0x34
2 0 0 00000000 00000024 24010008
2 0 0 00000000 00000028 10000003
2 0 0 00000000 00000034 2401000a
// JR to the register value 0x60
2 0 0 00000000 00000038 2401000d
2 0 0 00000060 0000003c 03e00008
2 0 0 00000060 00000060 2401000f
// issue stall then execute stall give bubbles at the held PC
2 1 0 00000000 00000060 00000000
2 0 1 00000000 00000060 00000000
// SYSCALL to the exception vector
2 0 0 00000000 00000064 24010018
2 0 0 00000000 00000068 0000000c
2 0 0 00000000 00000040 2401001a
2 0 0 00000000 00000044 24010010
2 0 0 00000000 00000048 24010011
// J sits in IF/ID when the stall comes and must survive it
2 0 0 00000000 0000004c 08000014
2 1 0 00000000 0000004c 00000000
2 1 1 00000000 0000004c 00000000
2 0 0 00000000 00000050 24010013
2 0 0 00000000 00000054 24010014
2 0 0 00000000 00000058 24010015
2 0 0 00000000 0000005c 24010016
0 0 0 0 0 0
